//--- common/mgmt_cmd_if.sv
interface mgmt_cmd_if;
	import mgmt_pkg::*;

	// Single-cycle read and write strobes
	logic rd;
	logic wr;

	// Target register
	mgmt_reg_t op;
	// Mux select number for REG_MUXSEL
	logic [3:0] index;
	logic [7:0] wdata;

	// Decode stage produces the command
	modport decode (output rd, output wr, output op, output index, output wdata);

	// Write side only
	modport execute (input wr, input op, input index, input wdata);

	// Read side only
	modport result (input rd, input op, input index);

endinterface

//--- common/mgmt_pkg.sv
package mgmt_pkg;

	//////////////////////////////////////////////////
	// Register opcodes

	// Decoded register targets on the management bus
	typedef enum logic [3:0] {
		REG_NONE,
		REG_ID,
		REG_SCRATCH,
		REG_FAN0_LO,
		REG_FAN0_HI,
		REG_FAN1_LO,
		REG_FAN1_HI,
		REG_MUXSEL,
		REG_FRONT_CS,
		REG_FRONT_DATA,
		REG_FRONT_STATUS
	} mgmt_reg_t;

	// One crossbar output select
	typedef logic [3:0] muxsel_t;

	localparam int NUM_MUXSEL = 12;

	// Board identification byte
	localparam logic [7:0] MGMT_ID_VALUE = 8'hA5;

	//////////////////////////////////////////////////
	// Address map

	localparam logic [15:0] ADDR_ID = 16'h0000;
	localparam logic [15:0] ADDR_SCRATCH = 16'h0001;
	localparam logic [15:0] ADDR_FAN0_LO = 16'h0010;
	localparam logic [15:0] ADDR_FAN0_HI = 16'h0011;
	localparam logic [15:0] ADDR_FAN1_LO = 16'h0012;
	localparam logic [15:0] ADDR_FAN1_HI = 16'h0013;
	localparam logic [15:0] ADDR_FRONT_CS = 16'h0020;
	localparam logic [15:0] ADDR_FRONT_DATA = 16'h0021;
	localparam logic [15:0] ADDR_FRONT_STATUS = 16'h0022;
	// Mux select i lives at base plus i
	localparam logic [15:0] ADDR_MUXSEL_BASE = 16'h0040;

	//////////////////////////////////////////////////
	// Sizing

	// sys_clk cycles per SPI half period
	localparam int SPI_CLKDIV = 4;
	localparam int SPI_DIV_W = $clog2(SPI_CLKDIV + 1);
	// Tach counting window in sys_clk cycles
	localparam int TACH_WINDOW = 2000;
	localparam int TACH_WIN_W = $clog2(TACH_WINDOW + 1);

endpackage

//--- dv/mgmt_tb.sv
module mgmt_tb;
	import mgmt_pkg::*;

	// Tach periods in sys_clk cycles
	localparam int FAN0_PERIOD = 50;
	localparam int FAN1_PERIOD = 80;
	// One byte shift as seen on busy
	localparam int SPI_CYCLES = 16 * SPI_CLKDIV;
	// Three tach windows of waiting plus SPI shifts and some 300 bus cycles with margin
	localparam int TIMEOUT_CYCLES = 20000;
	localparam logic [31:0] SEED = 32'h2e48_2752;

	logic sys_clk = 1'b0;
	logic rst_n;
	logic rd_en;
	logic [15:0] rd_addr;
	logic wr_en;
	logic [15:0] wr_addr;
	logic [7:0] wr_data;
	logic rd_valid;
	logic [7:0] rd_data;
	logic [1:0] fan_tach;
	logic frontpanel_sck;
	logic frontpanel_mosi;
	logic frontpanel_cs_n;
	logic frontpanel_miso;
	muxsel_t [NUM_MUXSEL-1:0] muxsel;

	int cyc = 0;
	// Responses checked so far and index into the expected queues
	int rd_done = 0;
	logic [7:0] last_rd_data;
	string test_name;
	logic [7:0] exp_data_q[$];
	int exp_cyc_q[$];
	string exp_name_q[$];

	// Shadow register model
	logic [7:0] scratch_m = 8'h00;
	logic [3:0] muxsel_m [NUM_MUXSEL] = '{default: 4'h0};
	logic cs_m = 1'b1;
	// Issue cycle of the last accepted FRONT_DATA write
	int spi_issue_cyc = -1000;
	logic [7:0] spi_rx_old = 8'h00;
	logic [7:0] spi_rx_new = 8'h00;

	// SPI device side
	logic [7:0] dev_tx_byte = 8'h00;
	logic [7:0] dev_rx_q[$];

	always #20 sys_clk = ~sys_clk;

	mgmt_subsystem mgmt_subsystem_i (.*);

	//////////////////////////////////////////////////
	// Checking helpers

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual)
			abort_run($sformatf("error %s: expected %0h, actual %0h", name, expected, actual));
	endtask

	// Expected read data for a read issued in cycle issue_cyc
	function automatic logic [7:0] expected_read(input logic [15:0] addr, input int issue_cyc);
		int d;
		logic [15:0] fan0;
		logic [15:0] fan1;
		// Write sampled at N pulses start after N+1 and holds busy after N+2 to N+65
		// New rx byte shows after N+66
		d = issue_cyc - spi_issue_cyc;
		fan0 = 16'(TACH_WINDOW / FAN0_PERIOD);
		fan1 = 16'(TACH_WINDOW / FAN1_PERIOD);
		if (addr >= ADDR_MUXSEL_BASE && addr < ADDR_MUXSEL_BASE + 16'(NUM_MUXSEL))
			return {4'h0, muxsel_m[4'(addr - ADDR_MUXSEL_BASE)]};
		case (addr)
			ADDR_ID: return MGMT_ID_VALUE;
			ADDR_SCRATCH: return scratch_m;
			ADDR_FAN0_LO: return fan0[7:0];
			ADDR_FAN0_HI: return fan0[15:8];
			ADDR_FAN1_LO: return fan1[7:0];
			ADDR_FAN1_HI: return fan1[15:8];
			ADDR_FRONT_CS: return {7'h00, cs_m};
			ADDR_FRONT_DATA: return (d > SPI_CYCLES + 1) ? spi_rx_new : spi_rx_old;
			ADDR_FRONT_STATUS: return {7'h00, d >= 2 && d <= SPI_CYCLES + 1};
			default: return 8'h00;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Bus tasks

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge sys_clk);
			#2;
		end
	endtask

	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		int d;
		d = cyc - spi_issue_cyc;
		// Shadow state follows the write at issue
		if (addr == ADDR_SCRATCH)
			scratch_m = data;
		if (addr >= ADDR_MUXSEL_BASE && addr < ADDR_MUXSEL_BASE + 16'(NUM_MUXSEL))
			muxsel_m[4'(addr - ADDR_MUXSEL_BASE)] = data[3:0];
		if (addr == ADDR_FRONT_CS)
			cs_m = data[0];
		// Dropped while a start is pending or busy is high
		if (addr == ADDR_FRONT_DATA && d > SPI_CYCLES + 1) begin
			spi_rx_old = spi_rx_new;
			spi_rx_new = dev_tx_byte;
			spi_issue_cyc = cyc;
		end
		wr_en = 1'b1;
		wr_addr = addr;
		wr_data = data;
		@(posedge sys_clk);
		#2;
		wr_en = 1'b0;
	endtask

	task automatic bus_read(input logic [15:0] addr);
		exp_data_q.push_back(expected_read(addr, cyc));
		exp_cyc_q.push_back(cyc + 2);
		exp_name_q.push_back(test_name);
		rd_en = 1'b1;
		rd_addr = addr;
		@(posedge sys_clk);
		#2;
		rd_en = 1'b0;
	endtask

	task automatic wait_reads_done();
		while (exp_data_q.size() != rd_done)
			idle_cycles(1);
	endtask

	// Poll FRONT_STATUS until busy reads back low
	task automatic wait_spi_idle();
		int target;
		do begin
			target = rd_done + 1;
			bus_read(ADDR_FRONT_STATUS);
			while (rd_done < target)
				idle_cycles(1);
		end while (last_rd_data[0]);
	endtask

	//////////////////////////////////////////////////
	// Response compare and timeout

	always @(negedge sys_clk) begin
		if (exp_cyc_q.size() > rd_done && exp_cyc_q[rd_done] < cyc)
			abort_run("rd_valid did not arrive for an outstanding read");
		else if (rd_valid === 1'b1) begin
			if (exp_cyc_q.size() == rd_done)
				abort_run("rd_valid was raised with no read outstanding");
			else begin
				check_value({exp_name_q[rd_done], "_latency"}, exp_cyc_q[rd_done], cyc);
				check_value(exp_name_q[rd_done], 32'(exp_data_q[rd_done]), 32'(rd_data));
				last_rd_data = rd_data;
				rd_done = rd_done + 1;
			end
		end
	end

	always @(posedge sys_clk) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT_CYCLES)
			abort_run("Timeout, the run did not finish within the cycle limit");
	end

	//////////////////////////////////////////////////
	// Tach sources and SPI device

	initial begin
		int tach_cyc;
		fan_tach = 2'b00;
		tach_cyc = 0;
		forever begin
			@(posedge sys_clk);
			#2;
			tach_cyc = tach_cyc + 1;
			if (tach_cyc % (FAN0_PERIOD / 2) == 0)
				fan_tach[0] = ~fan_tach[0];
			if (tach_cyc % (FAN1_PERIOD / 2) == 0)
				fan_tach[1] = ~fan_tach[1];
		end
	end

	// Mode 0 device where every 8 sck rises make one received byte
	initial begin
		logic [7:0] shift_in;
		frontpanel_miso = 1'b0;
		shift_in = 8'h00;
		@(negedge frontpanel_cs_n);
		#2;
		frontpanel_miso = dev_tx_byte[7];
		forever begin
			for (int nbit = 1; nbit <= 8; nbit++) begin
				@(posedge frontpanel_sck);
				shift_in = {shift_in[6:0], frontpanel_mosi};
				// Next MISO bit after the falling edge
				@(negedge frontpanel_sck);
				#2;
				frontpanel_miso = (nbit < 8) ? dev_tx_byte[7 - nbit] : dev_tx_byte[7];
			end
			dev_rx_q.push_back(shift_in);
		end
	end

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [7:0] data;
		logic [7:0] first_byte;
		rst_n = 1'b0;
		rd_en = 1'b0;
		rd_addr = '0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		void'($urandom(SEED));
		repeat (5) @(posedge sys_clk);
		#2;
		rst_n = 1'b1;

		// Idle outputs after reset
		test_name = "reset";
		check_value("reset_rd_valid", 0, 32'(rd_valid));
		check_value("reset_sck", 0, 32'(frontpanel_sck));
		check_value("reset_cs_n", 1, 32'(frontpanel_cs_n));
		check_value("reset_muxsel", 0, 32'(|muxsel));
		bus_read(ADDR_FRONT_STATUS);

		// ID, scratch readback, unmapped reads
		test_name = "id_scratch";
		bus_read(ADDR_ID);
		repeat (8) begin
			data = 8'($urandom);
			bus_write(ADDR_SCRATCH, data);
			bus_read(ADDR_SCRATCH);
		end
		test_name = "unmapped";
		bus_read(16'h0002);
		bus_read(16'h0014);
		bus_read(16'h0023);
		bus_read(16'h003F);
		bus_read(16'h004C);
		bus_read(16'hFFFF);
		wait_reads_done();

		// Mux selects keep the low nibble
		test_name = "muxsel";
		for (int i = 0; i < NUM_MUXSEL; i++) begin
			data = 8'($urandom);
			bus_write(ADDR_MUXSEL_BASE + 16'(i), data);
			idle_cycles(1);
			check_value($sformatf("muxsel_pin_%0d", i), 32'(muxsel_m[i]), 32'(muxsel[i]));
		end
		for (int i = 0; i < NUM_MUXSEL; i++)
			bus_read(ADDR_MUXSEL_BASE + 16'(i));
		wait_reads_done();

		// Reads on consecutive cycles
		test_name = "back_to_back";
		bus_write(ADDR_SCRATCH, 8'($urandom));
		bus_read(ADDR_ID);
		bus_read(ADDR_SCRATCH);
		bus_read(ADDR_MUXSEL_BASE + 16'd5);
		bus_read(16'h0030);
		bus_read(ADDR_FRONT_CS);
		bus_read(ADDR_MUXSEL_BASE + 16'd11);
		bus_read(ADDR_FRONT_STATUS);
		bus_read(ADDR_SCRATCH);
		wait_reads_done();

		// Front panel SPI with a write while busy
		test_name = "front_spi";
		dev_tx_byte = 8'($urandom);
		first_byte = 8'($urandom);
		bus_write(ADDR_FRONT_CS, 8'h00);
		idle_cycles(1);
		check_value("front_cs_pin_low", 0, 32'(frontpanel_cs_n));
		bus_write(ADDR_FRONT_DATA, first_byte);
		idle_cycles(4);
		bus_write(ADDR_FRONT_DATA, 8'($urandom));
		wait_spi_idle();
		check_value("spi_byte_count", 1, dev_rx_q.size());
		check_value("spi_mosi_byte", 32'(first_byte), 32'(dev_rx_q[0]));
		bus_read(ADDR_FRONT_DATA);
		bus_write(ADDR_FRONT_CS, 8'h01);
		idle_cycles(1);
		check_value("front_cs_pin_high", 1, 32'(frontpanel_cs_n));
		bus_read(ADDR_FRONT_CS);
		wait_reads_done();

		// Tach counts once two full windows have passed
		test_name = "fan_tach";
		while (cyc < 3 * TACH_WINDOW)
			idle_cycles(1);
		bus_read(ADDR_FAN0_LO);
		bus_read(ADDR_FAN0_HI);
		bus_read(ADDR_FAN1_LO);
		bus_read(ADDR_FAN1_HI);
		wait_reads_done();

		$display("Regression passed");
		$finish;
	end

endmodule

//--- logic/fan_tach_counter.sv
module fan_tach_counter (
	input logic sys_clk,
	input logic rst_n,
	input logic tach,
	output logic [15:0] count
);
	import mgmt_pkg::*;

	// Two-flop synchronizer plus previous value for edge detect
	logic tach_meta;
	logic tach_sync;
	logic tach_prev;

	logic [TACH_WIN_W-1:0] win_cnt;
	logic [15:0] edge_cnt;
	logic rise;
	logic win_end;

	assign rise = tach_sync & ~tach_prev;
	assign win_end = (win_cnt == TACH_WIN_W'(TACH_WINDOW - 1));

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			tach_meta <= 1'b0;
			tach_sync <= 1'b0;
			tach_prev <= 1'b0;
			win_cnt <= '0;
			edge_cnt <= '0;
			count <= '0;
		end else begin
			tach_meta <= tach;
			tach_sync <= tach_meta;
			tach_prev <= tach_sync;

			if (win_end) begin
				// Latch this window including an edge on its last cycle
				win_cnt <= '0;
				count <= edge_cnt + 16'(rise);
				edge_cnt <= '0;
			end else begin
				win_cnt <= win_cnt + 1'b1;
				edge_cnt <= edge_cnt + 16'(rise);
			end
		end
	end

endmodule

//--- logic/mgmt_subsystem.sv
module mgmt_subsystem (
	input logic sys_clk,
	input logic rst_n,
	input logic rd_en,
	input logic [15:0] rd_addr,
	input logic wr_en,
	input logic [15:0] wr_addr,
	input logic [7:0] wr_data,
	output logic rd_valid,
	output logic [7:0] rd_data,
	input logic [1:0] fan_tach,
	output logic frontpanel_sck,
	output logic frontpanel_mosi,
	output logic frontpanel_cs_n,
	input logic frontpanel_miso,
	output mgmt_pkg::muxsel_t [mgmt_pkg::NUM_MUXSEL-1:0] muxsel
);

	logic [15:0] fan0_count;
	logic [15:0] fan1_count;
	logic [7:0] scratch;
	logic spi_start;
	logic [7:0] spi_tx_data;
	logic spi_busy;
	logic [7:0] spi_rx_data;

	//////////////////////////////////////////////////
	// Fan tachometers

	fan_tach_counter fan_tach0 (
		.sys_clk(sys_clk),
		.rst_n(rst_n),
		.tach(fan_tach[0]),
		.count(fan0_count)
	);

	fan_tach_counter fan_tach1 (
		.sys_clk(sys_clk),
		.rst_n(rst_n),
		.tach(fan_tach[1]),
		.count(fan1_count)
	);

	//////////////////////////////////////////////////
	// Front panel SPI

	spi_host front_spi (
		.sys_clk(sys_clk),
		.rst_n(rst_n),
		.start(spi_start),
		.tx_data(spi_tx_data),
		.miso(frontpanel_miso),
		.sck(frontpanel_sck),
		.mosi(frontpanel_mosi),
		.busy(spi_busy),
		.rx_data(spi_rx_data)
	);

	//////////////////////////////////////////////////
	// Register pipeline

	// Decoded command shared by execute and result
	mgmt_cmd_if cmd_if ();

	mgmt_reg_decode reg_decode (
		.sys_clk(sys_clk),
		.rst_n(rst_n),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.cmd(cmd_if.decode)
	);

	mgmt_reg_execute reg_execute (
		.sys_clk(sys_clk),
		.rst_n(rst_n),
		.cmd(cmd_if.execute),
		.busy(spi_busy),
		.scratch(scratch),
		.muxsel(muxsel),
		.front_cs_n(frontpanel_cs_n),
		.spi_start(spi_start),
		.spi_tx_data(spi_tx_data)
	);

	mgmt_read_result read_result (
		.sys_clk(sys_clk),
		.rst_n(rst_n),
		.cmd(cmd_if.result),
		.scratch(scratch),
		.muxsel(muxsel),
		.front_cs_n(frontpanel_cs_n),
		.busy(spi_busy),
		.spi_rx_data(spi_rx_data),
		.fan0_count(fan0_count),
		.fan1_count(fan1_count),
		.rd_valid(rd_valid),
		.rd_data(rd_data)
	);

endmodule

//--- logic/spi_host.sv
module spi_host (
	input logic sys_clk,
	input logic rst_n,
	input logic start,
	input logic [7:0] tx_data,
	input logic miso,
	output logic sck,
	output logic mosi,
	output logic busy,
	output logic [7:0] rx_data
);
	import mgmt_pkg::*;

	// DONE is the final half period with sck high
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SHIFT,
		ST_DONE
	} spi_state_t;

	spi_state_t state;
	logic [SPI_DIV_W-1:0] div_cnt;
	// sck toggles so far in this byte
	logic [3:0] half_cnt;
	logic [7:0] tx_shift;
	logic [7:0] rx_shift;

	logic half_tick;
	logic rise_tick;
	logic fall_tick;

	assign half_tick = (div_cnt == SPI_DIV_W'(SPI_CLKDIV - 1));
	assign rise_tick = (state == ST_SHIFT) && half_tick && !sck;
	assign fall_tick = (state == ST_SHIFT) && half_tick && sck;
	assign busy = (state != ST_IDLE);

	//////////////////////////////////////////////////
	// Control and clock generation

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			div_cnt <= '0;
			half_cnt <= '0;
			sck <= 1'b0;
			mosi <= 1'b0;
			rx_data <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					div_cnt <= '0;
					half_cnt <= '0;
					if (start) begin
						// First bit goes out ahead of the first rising edge
						state <= ST_SHIFT;
						mosi <= tx_data[7];
					end
				end
				ST_SHIFT: begin
					div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
					if (half_tick) begin
						sck <= ~sck;
						half_cnt <= half_cnt + 1'b1;
						// Next bit on the falling edge
						if (sck)
							mosi <= tx_shift[6];
						// Toggle 15 is the last rising edge
						if (half_cnt == 4'd14)
							state <= ST_DONE;
					end
				end
				ST_DONE: begin
					div_cnt <= div_cnt + 1'b1;
					if (half_tick) begin
						sck <= 1'b0;
						mosi <= 1'b0;
						rx_data <= rx_shift;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Shift registers

	always_ff @(posedge sys_clk) begin
		if (state == ST_IDLE && start)
			tx_shift <= tx_data;
		else if (fall_tick)
			tx_shift <= {tx_shift[6:0], 1'b0};

		// MSB first on MISO as well
		if (rise_tick)
			rx_shift <= {rx_shift[6:0], miso};
	end

endmodule

//--- regs/mgmt_read_result.sv
module mgmt_read_result (
	input logic sys_clk,
	input logic rst_n,
	mgmt_cmd_if.result cmd,
	input logic [7:0] scratch,
	input mgmt_pkg::muxsel_t [mgmt_pkg::NUM_MUXSEL-1:0] muxsel,
	input logic front_cs_n,
	input logic busy,
	input logic [7:0] spi_rx_data,
	input logic [15:0] fan0_count,
	input logic [15:0] fan1_count,
	output logic rd_valid,
	output logic [7:0] rd_data
);
	import mgmt_pkg::*;

	logic [7:0] sel_data;

	// Read mux by opcode
	always_comb begin
		case (cmd.op)
			REG_ID: sel_data = MGMT_ID_VALUE;
			REG_SCRATCH: sel_data = scratch;
			REG_FAN0_LO: sel_data = fan0_count[7:0];
			REG_FAN0_HI: sel_data = fan0_count[15:8];
			REG_FAN1_LO: sel_data = fan1_count[7:0];
			REG_FAN1_HI: sel_data = fan1_count[15:8];
			REG_MUXSEL: sel_data = {4'h0, muxsel[cmd.index]};
			REG_FRONT_CS: sel_data = {7'h00, front_cs_n};
			REG_FRONT_DATA: sel_data = spi_rx_data;
			REG_FRONT_STATUS: sel_data = {7'h00, busy};
			// Unmapped reads return zero
			default: sel_data = 8'h00;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n)
			rd_valid <= 1'b0;
		else
			rd_valid <= cmd.rd;
	end

	// Data only loads on a read so it holds between reads
	always_ff @(posedge sys_clk) begin
		if (cmd.rd)
			rd_data <= sel_data;
	end

endmodule

//--- regs/mgmt_reg_decode.sv
module mgmt_reg_decode (
	input logic sys_clk,
	input logic rst_n,
	input logic rd_en,
	input logic [15:0] rd_addr,
	input logic wr_en,
	input logic [15:0] wr_addr,
	input logic [7:0] wr_data,
	mgmt_cmd_if.decode cmd
);
	import mgmt_pkg::*;

	logic [15:0] dec_addr;
	// Wraps for addresses below the mux base so one compare covers the range
	logic [15:0] mux_offset;
	mgmt_reg_t dec_op;
	logic [3:0] dec_index;

	//////////////////////////////////////////////////
	// Address decode

	always_comb begin
		// Shared decoder with read taking priority
		dec_addr = rd_en ? rd_addr : wr_addr;
		mux_offset = dec_addr - ADDR_MUXSEL_BASE;
		dec_op = REG_NONE;
		dec_index = '0;
		case (dec_addr)
			ADDR_ID: dec_op = REG_ID;
			ADDR_SCRATCH: dec_op = REG_SCRATCH;
			ADDR_FAN0_LO: dec_op = REG_FAN0_LO;
			ADDR_FAN0_HI: dec_op = REG_FAN0_HI;
			ADDR_FAN1_LO: dec_op = REG_FAN1_LO;
			ADDR_FAN1_HI: dec_op = REG_FAN1_HI;
			ADDR_FRONT_CS: dec_op = REG_FRONT_CS;
			ADDR_FRONT_DATA: dec_op = REG_FRONT_DATA;
			ADDR_FRONT_STATUS: dec_op = REG_FRONT_STATUS;
			default: begin
				if (mux_offset < 16'(NUM_MUXSEL)) begin
					dec_op = REG_MUXSEL;
					dec_index = mux_offset[3:0];
				end
			end
		endcase
	end

	//////////////////////////////////////////////////
	// Pipeline stage

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			cmd.rd <= 1'b0;
			cmd.wr <= 1'b0;
			cmd.op <= REG_NONE;
		end else begin
			cmd.rd <= rd_en;
			cmd.wr <= wr_en;
			cmd.op <= dec_op;
		end
	end

	// Mux index and write data travel with the strobes
	always_ff @(posedge sys_clk) begin
		cmd.index <= dec_index;
		cmd.wdata <= wr_data;
	end

endmodule

//--- regs/mgmt_reg_execute.sv
module mgmt_reg_execute (
	input logic sys_clk,
	input logic rst_n,
	mgmt_cmd_if.execute cmd,
	input logic busy,
	output logic [7:0] scratch,
	output mgmt_pkg::muxsel_t [mgmt_pkg::NUM_MUXSEL-1:0] muxsel,
	output logic front_cs_n,
	output logic spi_start,
	output logic [7:0] spi_tx_data
);
	import mgmt_pkg::*;

	// Data write accepted only with the SPI host idle
	// spi_start covers the cycle before busy rises
	logic shift_req;

	assign shift_req = cmd.wr && (cmd.op == REG_FRONT_DATA) && !busy && !spi_start;

	//////////////////////////////////////////////////
	// Writable registers

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			scratch <= '0;
			muxsel <= '0;
			// Front panel deselected out of reset
			front_cs_n <= 1'b1;
			spi_start <= 1'b0;
		end else begin
			// One-cycle start pulse
			spi_start <= shift_req;

			if (cmd.wr) begin
				case (cmd.op)
					REG_SCRATCH: scratch <= cmd.wdata;
					// Only the low nibble is kept
					REG_MUXSEL: muxsel[cmd.index] <= cmd.wdata[3:0];
					REG_FRONT_CS: front_cs_n <= cmd.wdata[0];
					// Read-only and unmapped targets drop the write
					default: ;
				endcase
			end
		end
	end

	// Byte held for the SPI host to load with the start pulse
	always_ff @(posedge sys_clk) begin
		if (shift_req)
			spi_tx_data <= cmd.wdata;
	end

endmodule

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary -j 0 --top-module mgmt_tb -f tb.f -o mgmt_tb_sim &&
./obj_dir/mgmt_tb_sim | tee /dev/stderr | grep -q "Regression passed" &&
echo "Simulation run OK" || { echo "Simulation run not OK"; exit 1; }

//--- tb.f
common/mgmt_pkg.sv
common/mgmt_cmd_if.sv
logic/fan_tach_counter.sv
logic/spi_host.sv
regs/mgmt_reg_decode.sv
regs/mgmt_reg_execute.sv
regs/mgmt_read_result.sv
logic/mgmt_subsystem.sv
dv/mgmt_tb.sv
